// File: design/algebraicBlock.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module algebraicBlock (
    input logic clk,
    input logic rstN,
    input logic start,
    input logic peakDone,
    input hisPkg::hisNumT peakHisNum,
    input hisPkg::binIdxT peakBin,
    winIf.src win
);
    import hisPkg::*;

    // timestamps per coarse bin
    localparam int CoarseW = 1 << (`Np - `Nb);

    logic coarseDone;
    timeStampT base;

    assign coarseDone = peakDone && (peakHisNum == COARSE);
    // peak bin moved back into the msbs
    assign base = {peakBin, {(`Np - `Nb){1'b0}}};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            win.winReady <= 1'b0;
        end else if (start) begin
            win.winReady <= 1'b0;
        end else if (coarseDone) begin
            win.winReady <= 1'b1;
        end
    end

    // window covers exactly the coarse peak bin
    always_ff @(posedge clk) begin
        if (coarseDone) begin
            win.thMinus <= base;
            win.thPositive <= timeStampT'(base + (CoarseW - 1));
            win.delta <= ($clog2(`Np))'(`Np - 2 * `Nb);
        end
    end

endmodule

// File: design/dataFilter.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module dataFilter (
    input logic clk,
    input logic rstN,
    input logic wrEn,
    input hisPkg::timeStampT roughData,
    input logic accept,
    input hisPkg::hisNumT hisNum,
    winIf.dst win,
    output logic binValid,
    output hisPkg::binIdxT binIdx
);
    import hisPkg::*;

    timeStampT offset;
    timeStampT shifted;
    logic inWin;
    binIdxT coarseIdx;
    binIdxT fineIdx;

    // coarse bin is simply the msbs
    assign coarseIdx = roughData[`Np-1 -: `Nb];

    // fine pass, position inside the coarse peak bin
    assign offset = roughData - win.thMinus;
    assign shifted = offset >> win.delta;
    assign fineIdx = shifted[`Nb-1:0];

    // bounds are inclusive on both sides
    assign inWin = win.winReady
        && (roughData >= win.thMinus)
        && (roughData <= win.thPositive);

    // valid only for accepted samples that survive the window
    always_ff @(posedge clk) begin
        if (!rstN) begin
            binValid <= 1'b0;
        end else begin
            binValid <= wrEn && accept && (hisNum == COARSE || inWin);
        end
    end

    // index is payload, qualified by binValid
    always_ff @(posedge clk) begin
        if (hisNum == COARSE) begin
            binIdx <= coarseIdx;
        end else begin
            binIdx <= fineIdx;
        end
    end

endmodule

// File: design/hisApbRegs.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module hisApbRegs (
    input logic clk,
    input logic rstN,
    input logic [`APB_AW-1:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    input hisPkg::hisStateT state,
    input hisPkg::hisNumT hisNum,
    input logic peakDone,
    input hisPkg::binIdxT peakBin,
    input hisPkg::binCountT peakCount,
    output logic start,
    output hisPkg::acqLenT acqLen,
    output logic done
);
    import hisPkg::*;

    logic access;
    logic busy;
    logic ctrlWr;
    acqLenT newLen;
    binIdxT peakCH;
    binIdxT peakFH;
    binCountT countCH;
    binCountT countFH;

    // no wait states, access always completes
    assign access = psel && penable;
    assign pready = access;
    assign busy = (state != IDLE);

    // ctrl is locked while a run is going
    assign ctrlWr = access && pwrite && (paddr == `REG_CTRL) && !busy;
    assign newLen = pwdata[8 +: `ACQ_W];
    assign start = ctrlWr && pwdata[0] && (newLen != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            acqLen <= '0;
            done <= 1'b0;
        end else begin
            if (ctrlWr) begin
                acqLen <= newLen;
            end
            // done rises with the fine peak
            if (start) begin
                done <= 1'b0;
            end else if (peakDone && hisNum == FINE) begin
                done <= 1'b1;
            end
        end
    end

    // each pass latches its own peak
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakCH <= '0;
            peakFH <= '0;
            countCH <= '0;
            countFH <= '0;
        end else if (peakDone) begin
            if (hisNum == COARSE) begin
                peakCH <= peakBin;
                countCH <= peakCount;
            end else begin
                peakFH <= peakBin;
                countFH <= peakCount;
            end
        end
    end

    // read mux, valid in the access phase
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                `REG_CTRL: prdata[8 +: `ACQ_W] = acqLen;
                `REG_STATUS: prdata[4:0] = {hisNum, state, done, busy};
                `REG_RESULT: begin
                    prdata[`Nb-1:0] = peakCH;
                    prdata[8 +: `Nb] = peakFH;
                    prdata[16 +: `peakMax] = countCH;
                    prdata[24 +: `peakMax] = countFH;
                end
                default: prdata = '0;
            endcase
        end
    end

endmodule

// File: design/hisBuilderFSM.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module hisBuilderFSM (
    input logic clk,
    input logic rstN,
    input logic start,
    input hisPkg::acqLenT acqLen,
    input logic wrEn,
    input logic binValid,
    input hisPkg::binIdxT binIdx,
    input logic peakDone,
    input logic winReady,
    scanIf.src scan,
    output logic accept,
    output hisPkg::hisNumT hisNum,
    output hisPkg::hisStateT state
);
    import hisPkg::*;

    localparam int BinNum = 1 << `Nb;

    // one histogram, reused by both passes
    binCountT mem [BinNum];
    acqLenT acqCnt;
    // last sample seen, pipe still busy
    logic draining;
    logic drainCnt;
    binIdxT scanPtr;
    // write stage of the read-modify-write
    logic updValid;
    binIdxT updAddr;
    binCountT updCount;
    logic fwd;
    binCountT rdCount;

    // fine pass waits for the window
    assign accept = (state == ACQ) && !draining && (hisNum == COARSE || winReady);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            hisNum <= COARSE;
            acqCnt <= '0;
            draining <= 1'b0;
            drainCnt <= 1'b0;
            scanPtr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= ACQ;
                        hisNum <= COARSE;
                        acqCnt <= '0;
                    end
                end
                ACQ: begin
                    if (draining) begin
                        // two cycles so the last sample reaches memory
                        drainCnt <= 1'b1;
                        if (drainCnt) begin
                            state <= SCAN;
                            scanPtr <= '0;
                            draining <= 1'b0;
                            drainCnt <= 1'b0;
                        end
                    end else if (accept && wrEn) begin
                        // filtered samples count too
                        acqCnt <= acqLenT'(acqCnt + 1'b1);
                        if (acqLenT'(acqCnt + 1'b1) == acqLen) begin
                            draining <= 1'b1;
                        end
                    end
                end
                SCAN: begin
                    scanPtr <= scanPtr + 1'b1;
                    if (&scanPtr) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    // wait for the peak, then fine pass or finish
                    if (peakDone) begin
                        if (hisNum == COARSE) begin
                            state <= ACQ;
                            hisNum <= FINE;
                            acqCnt <= '0;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // forward the bin still in the write stage
    assign fwd = updValid && (updAddr == binIdx);
    assign rdCount = fwd ? binCountT'(updCount + 1'b1) : mem[binIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            updValid <= 1'b0;
        end else begin
            updValid <= binValid;
        end
    end

    always_ff @(posedge clk) begin
        updAddr <= binIdx;
        updCount <= rdCount;
    end

    // scan clears each bin as it is read out
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < BinNum; i++) begin
                mem[i] <= '0;
            end
        end else if (state == SCAN) begin
            mem[scanPtr] <= '0;
        end else if (updValid) begin
            mem[updAddr] <= binCountT'(updCount + 1'b1);
        end
    end

    // sweep in address order
    assign scan.scanValid = (state == SCAN);
    assign scan.scanAddr = scanPtr;
    assign scan.scanCount = mem[scanPtr];
    assign scan.scanLast = (state == SCAN) && (&scanPtr);
    assign scan.hisNum = hisNum;

endmodule

// File: design/hisBuilder_consts.svh
`ifndef HISBUILDER_CONSTS_SVH
`define HISBUILDER_CONSTS_SVH

// timestamp width from the TDC
`define Np 10
// bin index width, 8 bins per histogram
`define Nb 3
// per-bin counter width
`define peakMax 8
// samples per pass, 1 to 255
`define ACQ_W 8

// apb address width
`define APB_AW 8
// register map
`define REG_CTRL 8'h00
`define REG_STATUS 8'h04
`define REG_RESULT 8'h08

`endif

// File: design/hisIfs.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

// scan stream, one bin per cycle from the builder to the peak detector
interface scanIf;
    import hisPkg::*;

    logic scanValid;
    binIdxT scanAddr;
    binCountT scanCount;
    // final bin of the sweep
    logic scanLast;
    hisNumT hisNum;

    modport src (output scanValid, scanAddr, scanCount, scanLast, hisNum);
    modport dst (input scanValid, scanAddr, scanCount, scanLast, hisNum);
endinterface

// fine window from the algebraic block to the data filter
interface winIf;
    import hisPkg::*;

    // lowest timestamp inside the window
    timeStampT thMinus;
    // highest timestamp inside the window
    timeStampT thPositive;
    // offset shift that leaves the fine bin index
    logic [$clog2(`Np)-1:0] delta;
    // window valid, coarse peak known
    logic winReady;

    modport src (output thMinus, thPositive, delta, winReady);
    modport dst (input thMinus, thPositive, delta, winReady);
endinterface

// File: design/hisPkg.sv
`include "hisBuilder_consts.svh"

package hisPkg;

    // raw tdc sample
    typedef logic [`Np-1:0] timeStampT;

    // histogram address
    typedef logic [`Nb-1:0] binIdxT;

    // one bin count
    typedef logic [`peakMax-1:0] binCountT;

    // accepted samples per pass
    typedef logic [`ACQ_W-1:0] acqLenT;

    // which histogram is being built
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } hisNumT;

    // builder FSM states, encoding is visible in STATUS
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ACQ  = 2'd1,
        SCAN = 2'd2,
        CALC = 2'd3
    } hisStateT;

endpackage

// File: design/hisTop.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module hisTop (
    input logic clk,
    input logic rstN,
    input logic [`APB_AW-1:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    input logic wrEn,
    input hisPkg::timeStampT roughData,
    output logic done
);
    import hisPkg::*;

    // control between the blocks
    logic start;
    acqLenT acqLen;
    hisStateT state;
    hisNumT hisNum;
    logic accept;
    // filtered bin into the builder
    logic binValid;
    binIdxT binIdx;
    // peak results
    binIdxT peakBin;
    binCountT peakCount;
    logic peakDone;
    hisNumT peakHisNum;

    scanIf scanBus ();
    winIf winBus ();

    hisApbRegs hisApbRegsU0 (
        .clk(clk),
        .rstN(rstN),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .state(state),
        .hisNum(hisNum),
        .peakDone(peakDone),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .start(start),
        .acqLen(acqLen),
        .done(done)
    );

    dataFilter dataFilterU0 (
        .clk(clk),
        .rstN(rstN),
        .wrEn(wrEn),
        .roughData(roughData),
        .accept(accept),
        .hisNum(hisNum),
        .win(winBus.dst),
        .binValid(binValid),
        .binIdx(binIdx)
    );

    hisBuilderFSM hisBuilderFSMU0 (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .acqLen(acqLen),
        .wrEn(wrEn),
        .binValid(binValid),
        .binIdx(binIdx),
        .peakDone(peakDone),
        .winReady(winBus.winReady),
        .scan(scanBus.src),
        .accept(accept),
        .hisNum(hisNum),
        .state(state)
    );

    peakDetecter peakDetecterU0 (
        .clk(clk),
        .rstN(rstN),
        .scan(scanBus.dst),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .peakDone(peakDone),
        .peakHisNum(peakHisNum)
    );

    algebraicBlock algebraicBlockU0 (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .peakDone(peakDone),
        .peakHisNum(peakHisNum),
        .peakBin(peakBin),
        .win(winBus.src)
    );

endmodule

// File: design/peakDetecter.sv
`timescale 1ns/1ps

module peakDetecter (
    input logic clk,
    input logic rstN,
    scanIf.dst scan,
    output hisPkg::binIdxT peakBin,
    output hisPkg::binCountT peakCount,
    output logic peakDone,
    output hisPkg::hisNumT peakHisNum
);

    logic firstBin;
    logic isHigher;

    // sweep always starts at bin zero
    assign firstBin = scan.scanValid && (scan.scanAddr == '0);
    // strict compare keeps the lowest index on a tie
    assign isHigher = scan.scanCount > peakCount;

    // one pulse on the cycle after the last bin
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakDone <= 1'b0;
        end else begin
            peakDone <= scan.scanValid && scan.scanLast;
        end
    end

    // tag the result with the pass being scanned
    always_ff @(posedge clk) begin
        if (!rstN) begin
            peakHisNum <= hisPkg::COARSE;
        end else if (firstBin) begin
            peakHisNum <= scan.hisNum;
        end
    end

    // running maximum
    always_ff @(posedge clk) begin
        if (firstBin) begin
            // restart from the first bin of each sweep
            peakBin <= scan.scanAddr;
            peakCount <= scan.scanCount;
        end else if (scan.scanValid && isHigher) begin
            peakBin <= scan.scanAddr;
            peakCount <= scan.scanCount;
        end
    end

endmodule

// File: dv/hisChecker.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module hisChecker (
    input logic clk,
    input logic rstN,
    input logic [`APB_AW-1:0] paddr,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] pwdata,
    input logic [31:0] prdata,
    input logic pready,
    input logic wrEn,
    input hisPkg::timeStampT roughData,
    input logic done,
    output int errCount,
    output int checkCount
);
    import hisPkg::*;

    localparam int BinNum = 1 << `Nb;
    // timestamps per coarse bin and per fine bin
    localparam int CoarseW = 1 << (`Np - `Nb);
    localparam int FineW = 1 << (`Np - 2 * `Nb);

    // reference state, as it stands after the last rising edge
    hisStateT mState;
    hisNumT mPass;
    logic mDone;
    logic draining;
    // cycles since the last sample of a pass
    int tick;
    int len;
    int accCnt;
    int coarseHist [BinNum];
    int fineHist [BinNum];
    // result register image
    int peakCH;
    int peakFH;
    int countCH;
    int countFH;
    logic access;

    assign access = psel && penable;

    initial begin
        errCount = 0;
        checkCount = 0;
    end

    // first bin holds, later bins must be strictly higher
    function automatic int peakOf(input int hist [BinNum]);
        int best;
        best = 0;
        for (int i = 1; i < BinNum; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic clearHists();
        for (int i = 0; i < BinNum; i++) begin
            coarseHist[i] = 0;
            fineHist[i] = 0;
        end
    endtask

    task automatic resetModel();
        mState = IDLE;
        mPass = COARSE;
        mDone = 1'b0;
        draining = 1'b0;
        tick = 0;
        len = 0;
        accCnt = 0;
        peakCH = 0;
        peakFH = 0;
        countCH = 0;
        countFH = 0;
        clearHists();
    endtask

    // fine pass keeps only the coarse peak bin, split into Nb more bits
    task automatic addSample(input int ts);
        int base;
        if (mPass == COARSE) begin
            coarseHist[ts / CoarseW]++;
        end else begin
            base = peakCH * CoarseW;
            if (ts >= base && ts < base + CoarseW) begin
                fineHist[(ts - base) / FineW]++;
            end
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compareOutputs();
        if (done !== mDone) begin
            errCount++;
            $display("FAILED done: got 0x%0h, expected 0x%0h", done, mDone);
        end
        // ready exactly in the access phase
        if (pready !== access) begin
            errCount++;
            $display("FAILED pready: got 0x%0h, expected 0x%0h", pready, access);
        end
        if (access && !pwrite) begin
            case (paddr)
                `REG_STATUS: begin
                    checkField("STATUS", prdata,
                        {27'd0, mPass, mState, mDone, mState != IDLE});
                end
                `REG_RESULT: begin
                    checkField("RESULT peakCH", prdata[`Nb-1:0], peakCH);
                    checkField("RESULT peakFH", prdata[8 +: `Nb], peakFH);
                    checkField("RESULT countCH", prdata[16 +: `peakMax], countCH);
                    checkField("RESULT countFH", prdata[24 +: `peakMax], countFH);
                end
                default: ;
            endcase
        end
    endtask

    // advance the model by the edge that follows
    task automatic stepModel();
        case (mState)
            IDLE: begin
                if (access && pwrite && paddr == `REG_CTRL && pwdata[0]
                        && pwdata[15:8] != 8'd0) begin
                    mState = ACQ;
                    mPass = COARSE;
                    mDone = 1'b0;
                    len = pwdata[15:8];
                    accCnt = 0;
                    draining = 1'b0;
                    clearHists();
                end
            end
            ACQ: begin
                if (draining) begin
                    tick++;
                    // two drain cycles
                    if (tick == 2) begin
                        mState = SCAN;
                    end
                end else if (wrEn) begin
                    addSample(roughData);
                    accCnt++;
                    if (accCnt == len) begin
                        draining = 1'b1;
                        tick = 0;
                    end
                end
            end
            SCAN: begin
                tick++;
                // eight bins swept
                if (tick == 10) begin
                    mState = CALC;
                end
            end
            CALC: begin
                // peak arrives, the pass ends
                draining = 1'b0;
                if (mPass == COARSE) begin
                    peakCH = peakOf(coarseHist);
                    countCH = coarseHist[peakCH];
                    mState = ACQ;
                    mPass = FINE;
                    accCnt = 0;
                end else begin
                    peakFH = peakOf(fineHist);
                    countFH = fineHist[peakFH];
                    mState = IDLE;
                    mDone = 1'b1;
                end
            end
            default: mState = IDLE;
        endcase
    endtask

    // falling edge, all inputs and outputs settled
    always @(negedge clk) begin
        if (!rstN) begin
            resetModel();
        end else begin
            compareOutputs();
            stepModel();
        end
    end

endmodule

// File: dv/hisTb.sv
`timescale 1ns/1ps
`include "hisBuilder_consts.svh"

module hisTb;
    import hisPkg::*;

    localparam logic [31:0] Seed = 32'h474f;
    localparam int MaxLen = 255;
    // six runs plus margin, each two passes of the longest length
    localparam int MaxRuns = 8;
    // one sample cycle plus up to three idle cycles
    localparam int SlotCycles = 4;
    // drain, scans, calc and the status polls
    localparam int RunOverhead = 460;
    localparam int TimeoutCycles = MaxRuns * (2 * MaxLen * SlotCycles + RunOverhead);

    logic clk;
    logic rstN;
    logic [`APB_AW-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic wrEn;
    timeStampT roughData;
    logic done;
    int errCount;
    int checkCount;
    int cycles = 0;
    int testNum = 0;
    int failTests = 0;
    int testErrs = 0;
    int hot;
    logic [31:0] rdData;
    timeStampT coarseQ [$];
    timeStampT fineQ [$];

    hisTop i_hisTop (.*);

    hisChecker chk (.*);

    bind hisTop hisTopAssert assertU0 (
        .clk(clk),
        .rstN(rstN),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pready(pready),
        .prdata(prdata),
        .done(done),
        .state(state)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TimeoutCycles) begin
            $display("timeout: run still busy after %0d cycles", TimeoutCycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // checker mismatches plus assertion failures
    function automatic int totalErrs();
        return errCount + i_hisTop.assertU0.failCount;
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task automatic apbWrite(input logic [`APB_AW-1:0] addr, input logic [31:0] data);
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbRead(input logic [`APB_AW-1:0] addr, output logic [31:0] data);
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        // mid access, prdata settled
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic sendSample(input timeStampT ts);
        int gap;
        wrEn = 1'b1;
        roughData = ts;
        @(posedge clk);
        #1;
        wrEn = 1'b0;
        // mostly back to back, sometimes a short gap
        gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic streamSamples(input timeStampT q [$]);
        foreach (q[i]) begin
            sendSample(q[i]);
        end
    endtask

    function automatic timeStampT makeStamp(input int coarse, input int fine);
        timeStampT ts;
        ts = timeStampT'($urandom);
        ts[`Np-1 -: `Nb] = coarse[`Nb-1:0];
        ts[`Np-`Nb-1 -: `Nb] = fine[`Nb-1:0];
        return ts;
    endfunction

    // one coarse bin and one fine sub-bin usually dominate
    function automatic timeStampT biasedSample(input int hotC, input int hotF);
        int coarse;
        int fine;
        coarse = ($urandom_range(0, 9) < 6) ? hotC : $urandom_range(0, 7);
        fine = ($urandom_range(0, 9) < 5) ? hotF : $urandom_range(0, 7);
        return makeStamp(coarse, fine);
    endfunction

    task automatic fillBiased(input int len, input int hotC);
        int hotF;
        hotF = $urandom_range(0, 7);
        coarseQ.delete();
        fineQ.delete();
        repeat (len) begin
            coarseQ.push_back(biasedSample(hotC, hotF));
            fineQ.push_back(biasedSample(hotC, hotF));
        end
    endtask

    task automatic startRun(input int len);
        apbWrite(`REG_CTRL, (len << 8) | 1);
    endtask

    // wait for the fine pass, stream it, wait for done, read the peaks
    task automatic finishRun();
        logic [31:0] st;
        st = '0;
        while (!(st[3:2] == ACQ && st[4] == FINE)) begin
            apbRead(`REG_STATUS, st);
        end
        streamSamples(fineQ);
        st = '0;
        while (!st[1]) begin
            apbRead(`REG_STATUS, st);
        end
        apbRead(`REG_RESULT, st);
    endtask

    task automatic fullRun();
        startRun(coarseQ.size());
        streamSamples(coarseQ);
        finishRun();
    endtask

    task automatic endTest(input string name);
        int errs;
        errs = totalErrs();
        testNum++;
        if (errs != testErrs) begin
            failTests++;
        end
        $display("test %0d %s: %s, %0d errors", testNum, name,
            (errs == testErrs) ? "ok" : "mismatch", errs - testErrs);
        testErrs = errs;
    endtask

    initial begin
        void'($urandom(Seed));
        rstN = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        wrEn = 1'b0;
        roughData = '0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        apbRead(`REG_STATUS, rdData);
        endTest("reset state");

        fillBiased($urandom_range(1, MaxLen), $urandom_range(0, 7));
        fullRun();
        endTest("random run");

        // coarse bins 5 and 2 tie, fine sub-bins 6 and 3 tie
        coarseQ.delete();
        fineQ.delete();
        for (int i = 0; i < 12; i++) begin
            coarseQ.push_back(makeStamp(i < 5 ? 5 : (i < 10 ? 2 : 0), $urandom_range(0, 7)));
            fineQ.push_back(makeStamp(2, i < 6 ? 6 : 3));
        end
        fullRun();
        endTest("tie to lowest bin");

        // half of the fine samples fall outside coarse bin 3
        coarseQ.delete();
        fineQ.delete();
        for (int i = 0; i < 40; i++) begin
            coarseQ.push_back(makeStamp(3, $urandom_range(0, 7)));
            if (i % 2 == 0) begin
                fineQ.push_back(makeStamp(3, 1));
            end else begin
                fineQ.push_back(makeStamp((4 + $urandom_range(0, 6)) % 8, $urandom_range(0, 7)));
            end
        end
        fullRun();
        endTest("fine window filter");

        // idle samples first, then a second start in the middle of the coarse pass
        repeat (10) begin
            sendSample(timeStampT'($urandom));
        end
        fillBiased(30, $urandom_range(0, 7));
        startRun(30);
        for (int i = 0; i < 15; i++) begin
            sendSample(coarseQ[i]);
        end
        startRun(5);
        apbRead(`REG_STATUS, rdData);
        for (int i = 15; i < 30; i++) begin
            sendSample(coarseQ[i]);
        end
        finishRun();
        endTest("idle samples and busy start");

        // a short run in another bin right after a long one
        hot = $urandom_range(0, 7);
        fillBiased($urandom_range(20, 100), hot);
        fullRun();
        coarseQ.delete();
        fineQ.delete();
        repeat (3) begin
            coarseQ.push_back(makeStamp((hot + 4) % 8, 0));
            fineQ.push_back(makeStamp((hot + 4) % 8, 0));
        end
        fullRun();
        endTest("back-to-back runs");

        $display("tests %0d, failing %0d, checks %0d, errors %0d",
            testNum, failTests, checkCount, totalErrs());
        if (totalErrs() == 0 && checkCount > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dv/hisTop_assert.sv
`timescale 1ns/1ps

module hisTopAssert (
    input logic clk,
    input logic rstN,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic pready,
    input logic [31:0] prdata,
    input logic done,
    input hisPkg::hisStateT state
);
    import hisPkg::*;

    int failCount = 0;

    // no wait states, ready marks the access phase only
    readyInAccess: assert property (@(posedge clk) disable iff (!rstN)
        pready == (psel && penable))
        else begin
            failCount++;
            $error("pready outside the access phase");
        end

    // done and busy are exclusive
    doneNotBusy: assert property (@(posedge clk) disable iff (!rstN)
        done |-> (state == IDLE))
        else begin
            failCount++;
            $error("done high while the builder is busy");
        end

    // read data driven in the access phase
    prdataKnown: assert property (@(posedge clk) disable iff (!rstN)
        (psel && penable && !pwrite) |-> !$isunknown(prdata))
        else begin
            failCount++;
            $error("prdata unknown during a read access");
        end

endmodule

// File: verilog.f
+incdir+design
design/hisPkg.sv
design/hisIfs.sv
design/dataFilter.sv
design/hisBuilderFSM.sv
design/peakDetecter.sv
design/algebraicBlock.sv
design/hisApbRegs.sv
design/hisTop.sv
dv/hisTop_assert.sv
dv/hisChecker.sv
dv/hisTb.sv
